/* source/alut_pkg.sv */
// alut sizes, register map, table/frame/request structs and address hash function
`default_nettype none

package alut_pkg;

   // ----------------------------------------------------------
   // sizes
   // ----------------------------------------------------------
   localparam int unsigned alut_addr_w  = 48;   // mac address
   localparam int unsigned alut_time_w  = 32;   // timestamp
   localparam int unsigned alut_hash_w  = 8;    // table index
   localparam int unsigned alut_depth   = 256;  // entries, one per hash value
   localparam int unsigned alut_port_w  = 2;    // encoded source port
   localparam int unsigned alut_dport_w = 5;    // dest mask, bit 4 is the mac port

   localparam logic [1:0] alut_cmd_check = 2'b01;  // only command acted on
   localparam logic [alut_dport_w-1:0] alut_dport_rst = 5'h0F;
   localparam logic [alut_dport_w-1:0] alut_dport_mac = 5'h10;

   // ----------------------------------------------------------
   // apb register offsets
   // ----------------------------------------------------------
   localparam logic [7:0] alut_reg_cmd      = 8'h00;
   localparam logic [7:0] alut_reg_status   = 8'h04;  // bit0 active, bit1 reused
   localparam logic [7:0] alut_reg_mac_lo   = 8'h08;
   localparam logic [7:0] alut_reg_mac_hi   = 8'h0C;
   localparam logic [7:0] alut_reg_daddr_lo = 8'h10;
   localparam logic [7:0] alut_reg_daddr_hi = 8'h14;
   localparam logic [7:0] alut_reg_saddr_lo = 8'h18;
   localparam logic [7:0] alut_reg_saddr_hi = 8'h1C;  // source port in 17:16
   localparam logic [7:0] alut_reg_dport    = 8'h20;
   localparam logic [7:0] alut_reg_inv_lo   = 8'h24;
   localparam logic [7:0] alut_reg_inv_hi   = 8'h28;  // evicted port in 17:16, read clears reused
   localparam logic [7:0] alut_reg_max_age  = 8'h2C;

   // table entry, valid in the top bit (83 bits)
   typedef struct packed {
      logic                   valid;
      logic [alut_time_w-1:0] last_time;  // time of last learn
      logic [alut_port_w-1:0] port;
      logic [alut_addr_w-1:0] addr;
   } alut_entry_t;

   typedef struct packed {
      logic [alut_addr_w-1:0] d_addr;   // address looked up
      logic [alut_addr_w-1:0] s_addr;   // address learned
      logic [alut_port_w-1:0] s_port;
   } alut_frame_t;

   typedef struct packed {
      logic                   write;
      logic [alut_hash_w-1:0] index;
      alut_entry_t            wr_entry;
   } alut_mem_req_t;

   typedef struct packed {
      logic                   req;        // one cycle pulse
      logic [alut_time_w-1:0] last_time;
   } alut_age_req_t;

   typedef struct packed {
      logic confirmed;  // answer present this cycle
      logic ok;         // entry still in date
   } alut_age_rsp_t;

   // xor of the six address bytes
   function automatic logic [alut_hash_w-1:0] alut_hash(input logic [alut_addr_w-1:0] addr);
      logic [alut_hash_w-1:0] h;
      h = '0;
      for (int i = 0; i < alut_addr_w / 8; i++)
         h ^= addr[i*8 +: 8];
      return h;
   endfunction

endpackage

`default_nettype wire

/* source/alut_apb_regs.sv */
// alut apb register file, check command pulse, reused read-and-clear and busy write block
`timescale 1ns/1ps
`default_nettype none

module alut_apb_regs
(
   input  logic                               pclk12,
   input  logic                               n_p_reset12,
   input  logic                               psel,
   input  logic                               penable,
   input  logic                               pwrite,
   input  logic [7:0]                         paddr,
   input  logic [31:0]                        pwdata,
   input  logic                               active,        // check in progress
   input  logic [alut_pkg::alut_dport_w-1:0]  d_port,
   input  logic                               reused,
   input  logic [alut_pkg::alut_addr_w-1:0]   lst_inv_addr,
   input  logic [alut_pkg::alut_port_w-1:0]   lst_inv_port,
   output logic [31:0]                        prdata,
   output logic [1:0]                         command,       // one cycle after a cmd write
   output logic                               clear_reused,
   output logic [alut_pkg::alut_addr_w-1:0]   mac_addr,
   output alut_pkg::alut_frame_t              frame,
   output logic [alut_pkg::alut_time_w-1:0]   max_age
);

   import alut_pkg::*;

   logic wr_en;  // access phase write
   logic rd_en;  // access phase read

   assign wr_en = psel & penable & pwrite;
   assign rd_en = psel & penable & ~pwrite;

   // access phase lasts one cycle so this is already a single pulse
   assign clear_reused = rd_en & (paddr == alut_reg_inv_hi);

   // ----------------------------------------------------------
   // register writes
   // ----------------------------------------------------------
   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
      begin
         command  <= 2'b00;
         mac_addr <= '0;
         frame    <= '0;
         max_age  <= '1;  // everything in date
      end
      else
      begin
         command <= 2'b00;  // pulse only
         if (wr_en)
         begin
            case (paddr)
               alut_reg_cmd:
                  if (!active)
                     command <= pwdata[1:0];
               alut_reg_mac_lo:   mac_addr[31:0]            <= pwdata;
               alut_reg_mac_hi:   mac_addr[alut_addr_w-1:32] <= pwdata[15:0];
               alut_reg_daddr_lo:
                  if (!active)
                     frame.d_addr[31:0] <= pwdata;
               alut_reg_daddr_hi:
                  if (!active)
                     frame.d_addr[alut_addr_w-1:32] <= pwdata[15:0];
               alut_reg_saddr_lo:
                  if (!active)
                     frame.s_addr[31:0] <= pwdata;
               alut_reg_saddr_hi:
                  if (!active)
                  begin
                     frame.s_addr[alut_addr_w-1:32] <= pwdata[15:0];
                     frame.s_port                   <= pwdata[17:16];
                  end
               alut_reg_max_age:  max_age <= pwdata;
               default: ;  // read-only or unmapped
            endcase
         end
      end
   end

   // ----------------------------------------------------------
   // read mux, no wait states
   // ----------------------------------------------------------
   always_comb
   begin
      prdata = '0;
      case (paddr)
         alut_reg_status:   prdata = {30'd0, reused, active};
         alut_reg_mac_lo:   prdata = mac_addr[31:0];
         alut_reg_mac_hi:   prdata = {16'd0, mac_addr[alut_addr_w-1:32]};
         alut_reg_daddr_lo: prdata = frame.d_addr[31:0];
         alut_reg_daddr_hi: prdata = {16'd0, frame.d_addr[alut_addr_w-1:32]};
         alut_reg_saddr_lo: prdata = frame.s_addr[31:0];
         alut_reg_saddr_hi: prdata = {14'd0, frame.s_port, frame.s_addr[alut_addr_w-1:32]};
         alut_reg_dport:    prdata = {27'd0, d_port};
         alut_reg_inv_lo:   prdata = lst_inv_addr[31:0];
         alut_reg_inv_hi:   prdata = {14'd0, lst_inv_port, lst_inv_addr[alut_addr_w-1:32]};
         alut_reg_max_age:  prdata = max_age;
         default:           prdata = '0;  // cmd reads back zero
      endcase
   end

endmodule

`default_nettype wire

/* source/alut_addr_checker.sv */
// alut check-and-learn fsm, destination port decision and evicted entry tracking
`timescale 1ns/1ps
`default_nettype none

module alut_addr_checker
(
   input  logic                               pclk12,
   input  logic                               n_p_reset12,
   input  logic [1:0]                         command,
   input  logic [alut_pkg::alut_addr_w-1:0]   mac_addr,
   input  alut_pkg::alut_frame_t              frame,
   input  logic [alut_pkg::alut_time_w-1:0]   curr_time,
   input  alut_pkg::alut_entry_t              rd_entry,      // table data at mem_req.index
   input  alut_pkg::alut_age_rsp_t            age_rsp,
   input  logic                               clear_reused,
   output logic [alut_pkg::alut_dport_w-1:0]  d_port,
   output logic                               active,
   output alut_pkg::alut_mem_req_t            mem_req,
   output alut_pkg::alut_age_req_t            age_req,
   output logic                               reused,
   output logic [alut_pkg::alut_addr_w-1:0]   lst_inv_addr,
   output logic [alut_pkg::alut_port_w-1:0]   lst_inv_port
);

   import alut_pkg::*;

   typedef enum logic [2:0] {
      st_idle, st_mac_chk, st_read_dst, st_valid_chk,
      st_age_chk, st_addr_chk, st_read_src, st_write_src
   } chk_state_t;

   chk_state_t state;
   chk_state_t nxt_state;

   logic [alut_hash_w-1:0]  d_hash;
   logic [alut_hash_w-1:0]  s_hash;
   logic                    mac_hit;      // frame is for the switch itself
   logic                    dst_ok;       // dest entry valid and in date so far
   logic                    dst_hit;
   logic [alut_dport_w-1:0] src_bit;      // never send back on the source port
   logic [alut_dport_w-1:0] stored_mask;  // one-hot of stored port

   assign d_hash      = alut_hash(frame.d_addr);
   assign s_hash      = alut_hash(frame.s_addr);
   assign mac_hit     = (frame.d_addr == mac_addr);
   assign dst_hit     = dst_ok & (rd_entry.addr == frame.d_addr);
   assign src_bit     = alut_dport_w'(1) << frame.s_port;
   assign stored_mask = alut_dport_w'(1) << rd_entry.port;  // bits 3:0 only
   assign active      = (state != st_idle);

   // ----------------------------------------------------------
   // check-and-learn fsm
   // ----------------------------------------------------------
   always_comb
   begin
      nxt_state = state;
      case (state)
         st_idle:
            if (command == alut_cmd_check)
               nxt_state = st_mac_chk;
         st_mac_chk:   nxt_state = mac_hit ? st_idle : st_read_dst;  // mac hit learns nothing
         st_read_dst:  nxt_state = st_valid_chk;  // index moves to dest hash
         st_valid_chk: nxt_state = st_age_chk;
         st_age_chk:
            if (age_rsp.confirmed)
               nxt_state = st_addr_chk;   // wait for age answer
         st_addr_chk:  nxt_state = st_read_src;   // decide port, index to source hash
         st_read_src:  nxt_state = st_write_src;  // look at the entry about to be replaced
         default:      nxt_state = st_idle;       // write_src, table written at this edge
      endcase
   end

   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
         state <= st_idle;
      else
         state <= nxt_state;
   end

   // destination port decision
   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
         d_port <= alut_dport_rst;
      else if ((state == st_mac_chk) && mac_hit)
         d_port <= alut_dport_mac;
      else if (state == st_addr_chk)
         d_port <= (dst_hit ? stored_mask : alut_dport_rst) & ~src_bit;  // hit or flood
   end

   // valid then age result folded into one flag for addr_chk
   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
         dst_ok <= 1'b0;
      else if (state == st_valid_chk)
         dst_ok <= rd_entry.valid;
      else if ((state == st_age_chk) && age_rsp.confirmed)
         dst_ok <= dst_ok & age_rsp.ok;
   end

   // ----------------------------------------------------------
   // table access and age request
   // ----------------------------------------------------------
   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
      begin
         mem_req <= '0;
         age_req <= '0;
      end
      else
      begin
         mem_req.write <= (state == st_read_src);  // high during write_src
         if (state == st_read_dst)
            mem_req.index <= d_hash;
         else if (state == st_addr_chk)
            mem_req.index <= s_hash;  // held through read_src and write_src
         if (state == st_read_src)
            mem_req.wr_entry <= '{valid: 1'b1, last_time: curr_time,
                                  port: frame.s_port, addr: frame.s_addr};
         age_req.req <= (state == st_valid_chk);  // single pulse per check
         if (state == st_valid_chk)
            age_req.last_time <= rd_entry.last_time;
      end
   end

   // ----------------------------------------------------------
   // eviction of a different valid address, reused is read-and-clear
   // ----------------------------------------------------------
   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
      begin
         reused       <= 1'b0;
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if ((state == st_read_src) && rd_entry.valid && (rd_entry.addr != frame.s_addr))
      begin
         reused       <= 1'b1;  // set wins over a clear in the same cycle
         lst_inv_addr <= rd_entry.addr;
         lst_inv_port <= rd_entry.port;
      end
      else if (clear_reused)
         reused <= 1'b0;
   end

endmodule

`default_nettype wire

/* source/alut_age_checker.sv */
// alut free-running time counter and in-date check against max age
`timescale 1ns/1ps
`default_nettype none

module alut_age_checker
(
   input  logic                              pclk12,
   input  logic                              n_p_reset12,
   input  alut_pkg::alut_age_req_t           age_req,
   input  logic [alut_pkg::alut_time_w-1:0]  max_age,
   output alut_pkg::alut_age_rsp_t           age_rsp,
   output logic [alut_pkg::alut_time_w-1:0]  curr_time
);

   import alut_pkg::*;

   logic [alut_time_w-1:0] elapsed;  // wraps cleanly past counter rollover

   assign elapsed = curr_time - age_req.last_time;

   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
         curr_time <= '0;
      else
         curr_time <= curr_time + 1'b1;  // one tick per clock
   end

   // answer exactly one cycle after the request pulse
   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
         age_rsp <= '0;
      else
      begin
         age_rsp.confirmed <= age_req.req;
         age_rsp.ok        <= age_req.req & (elapsed <= max_age);
      end
   end

endmodule

`default_nettype wire

/* source/alut_mem.sv */
// alut 256-entry table, asynchronous read and synchronous write
`timescale 1ns/1ps
`default_nettype none

module alut_mem
(
   input  logic                     pclk12,
   input  logic                     n_p_reset12,
   input  alut_pkg::alut_mem_req_t  mem_req,
   output alut_pkg::alut_entry_t    rd_entry
);

   import alut_pkg::*;

   alut_entry_t entries [alut_depth];

   assign rd_entry = entries[mem_req.index];  // read at the registered index

   always_ff @(posedge pclk12 or negedge n_p_reset12)
   begin
      if (!n_p_reset12)
      begin
         for (int i = 0; i < alut_depth; i++)
            entries[i] <= '0;  // all invalid
      end
      else if (mem_req.write)
         entries[mem_req.index] <= mem_req.wr_entry;
   end

endmodule

`default_nettype wire

/* source/alut_top.sv */
// alut top level with register block, address checker, age checker and table
`timescale 1ns/1ps
`default_nettype none

module alut_top
(
   input  logic        pclk12,
   input  logic        n_p_reset12,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [7:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata
);

   import alut_pkg::*;

   // ----------------------------------------------------------
   // interconnect
   // ----------------------------------------------------------
   logic [1:0]              command;
   logic                    clear_reused;
   logic [alut_addr_w-1:0]  mac_addr;
   alut_frame_t             frame;
   logic [alut_time_w-1:0]  max_age;
   logic                    active;
   logic [alut_dport_w-1:0] d_port;
   logic                    reused;
   logic [alut_addr_w-1:0]  lst_inv_addr;
   logic [alut_port_w-1:0]  lst_inv_port;
   alut_mem_req_t           mem_req;
   alut_entry_t             rd_entry;
   alut_age_req_t           age_req;
   alut_age_rsp_t           age_rsp;
   logic [alut_time_w-1:0]  curr_time;

   alut_apb_regs u_regs (
      .pclk12, .n_p_reset12,
      .psel, .penable, .pwrite, .paddr, .pwdata,
      .active, .d_port, .reused, .lst_inv_addr, .lst_inv_port,
      .prdata, .command, .clear_reused, .mac_addr, .frame, .max_age
   );

   alut_addr_checker u_checker (
      .pclk12, .n_p_reset12,
      .command, .mac_addr, .frame, .curr_time, .rd_entry, .age_rsp, .clear_reused,
      .d_port, .active, .mem_req, .age_req, .reused, .lst_inv_addr, .lst_inv_port
   );

   alut_age_checker u_age (
      .pclk12, .n_p_reset12,
      .age_req, .max_age,
      .age_rsp, .curr_time
   );

   alut_mem u_mem (
      .pclk12, .n_p_reset12,
      .mem_req,
      .rd_entry
   );

endmodule

`default_nettype wire

/* verif/alut_sva.sv */
// concurrent assertions on the address checker outputs, bound into alut_addr_checker
`timescale 1ns/1ps
`default_nettype none

module alut_checker_sva
(
   input logic                               pclk12,
   input logic                               n_p_reset12,
   input logic [alut_pkg::alut_dport_w-1:0]  d_port,
   input logic                               active,
   input alut_pkg::alut_mem_req_t            mem_req,
   input alut_pkg::alut_age_req_t            age_req,
   input logic                               reused
);

   // mac port is never mixed with switch ports
   mac_port_alone: assert property (@(posedge pclk12) disable iff (!n_p_reset12)
      d_port[4] |-> (d_port[3:0] == 4'h0))
      else $error("d_port mixes the mac bit with other ports: %h", d_port);

   write_when_active: assert property (@(posedge pclk12) disable iff (!n_p_reset12)
      mem_req.write |-> active)
      else $error("table write outside a check");

   age_when_active: assert property (@(posedge pclk12) disable iff (!n_p_reset12)
      age_req.req |-> active)
      else $error("age request outside a check");

   reused_when_active: assert property (@(posedge pclk12) disable iff (!n_p_reset12)
      $rose(reused) |-> active)  // set only from read_src
      else $error("reused rose outside a check");

endmodule

bind alut_addr_checker alut_checker_sva u_sva (
   .pclk12(pclk12), .n_p_reset12(n_p_reset12), .d_port(d_port), .active(active),
   .mem_req(mem_req), .age_req(age_req), .reused(reused)
);

`default_nettype wire

/* verif/tb_alut.sv */
// alut testbench with apb tasks, table reference model, directed tests and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_alut;

   import alut_pkg::*;

   localparam int clk_period      = 8;
   localparam int num_tests       = 5;
   localparam int cycles_per_test = 200;  // generous bound for one test
   localparam int max_polls       = 40;

   logic        pclk12;
   logic        n_p_reset12;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;

   integer seed;
   int     errors;
   int     test_errors;
   int     tests_failed;

   // reference table, one slot per byte-xor index
   bit          m_valid [alut_depth];
   logic [47:0] m_addr  [alut_depth];
   logic [1:0]  m_port  [alut_depth];
   logic [47:0] mac;
   logic [47:0] learned_addr;  // source learned in test 3, reused in test 4

   alut_top dut (
      .pclk12, .n_p_reset12, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata
   );

   always #(clk_period / 2) pclk12 = ~pclk12;

   // ----------------------------------------------------------
   // bus tasks and checks
   // ----------------------------------------------------------
   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      @(posedge pclk12);
      #1 {psel, penable, pwrite, paddr, pwdata} = {3'b101, addr, data};  // setup
      @(posedge pclk12);
      #1 penable = 1'b1;  // access, write lands at next edge
      @(posedge pclk12);
      #1 {psel, penable} = 2'b00;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      @(posedge pclk12);
      #1 {psel, penable, pwrite, paddr} = {3'b100, addr};
      @(posedge pclk12);
      #1 penable = 1'b1;
      #2 data = prdata;  // mid access phase
      @(posedge pclk12);
      #1 {psel, penable} = 2'b00;
   endtask

   task automatic check_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   task automatic wait_idle();
      logic [31:0] st;
      int          n;
      n = 0;
      st = 32'h1;
      while (st[0] && (n < max_polls))
      begin
         apb_read(alut_reg_status, st);
         n++;
      end
      if (st[0])
      begin
         $display("checker still busy after %0d status reads", max_polls);
         errors++;
         test_errors++;
      end
   endtask

   task automatic report_test(input string name);
      if (test_errors == 0)
         $display("test %s: ok", name);
      else
      begin
         $display("test %s: %0d errors", name, test_errors);
         tests_failed++;
      end
      test_errors = 0;
   endtask

   function automatic logic [47:0] rand_addr();
      logic [31:0] lo;
      logic [31:0] hi;
      lo = $random(seed);
      hi = $random(seed);
      return {hi[15:0], lo};
   endfunction

   // ----------------------------------------------------------
   // reference model
   // ----------------------------------------------------------
   function automatic logic [7:0] table_index(input logic [47:0] a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ a[39:32] ^ a[47:40];
   endfunction

   function automatic logic [4:0] predict_dport(input logic [47:0] d, input logic [1:0] sp,
                                                input bit stale);
      logic [7:0] idx;
      logic [4:0] src_mask;
      idx = table_index(d);
      src_mask = 5'd1 << sp;
      if (d == mac)
         return 5'h10;
      if (m_valid[idx] && (m_addr[idx] == d) && !stale)
         return (5'd1 << m_port[idx]) & ~src_mask;  // known, forward
      return 5'h0F & ~src_mask;  // flood
   endfunction

   // write frame, start the check, compare d_port, then learn in the model
   task automatic run_check(input logic [47:0] d, input logic [47:0] s, input logic [1:0] sp,
                            input bit stale);
      logic [31:0] rd;
      logic [4:0]  exp;
      logic [7:0]  idx;
      exp = predict_dport(d, sp, stale);
      apb_write(alut_reg_daddr_lo, d[31:0]);
      apb_write(alut_reg_daddr_hi, {16'd0, d[47:32]});
      apb_write(alut_reg_saddr_lo, s[31:0]);
      apb_write(alut_reg_saddr_hi, {14'd0, sp, s[47:32]});
      apb_write(alut_reg_cmd, 32'h1);
      wait_idle();
      apb_read(alut_reg_dport, rd);
      check_equal("d_port", 64'(rd), 64'(exp));
      if (d != mac)
      begin
         idx = table_index(s);
         m_valid[idx] = 1'b1;
         m_addr[idx]  = s;
         m_port[idx]  = sp;
      end
   endtask

   // ----------------------------------------------------------
   // directed tests
   // ----------------------------------------------------------
   task automatic test_reset();
      logic [31:0] rd;
      apb_read(alut_reg_status, rd);
      check_equal("status", 64'(rd), 64'h0);
      apb_read(alut_reg_dport, rd);
      check_equal("d_port", 64'(rd), 64'h0F);
      report_test("1 reset values");
   endtask

   task automatic test_mac_hit();
      logic [47:0] sa;
      mac = rand_addr();
      sa  = rand_addr();
      apb_write(alut_reg_mac_lo, mac[31:0]);
      apb_write(alut_reg_mac_hi, {16'd0, mac[47:32]});
      run_check(mac, sa, 2'd2, 1'b0);          // to the switch itself
      run_check(sa, rand_addr(), 2'd1, 1'b0);  // sa was not learned
      report_test("2 mac hit");
   endtask

   task automatic test_learn();
      logic [47:0] s1;
      s1 = rand_addr();
      run_check(rand_addr(), s1, 2'd2, 1'b0);  // unknown dest floods
      run_check(s1, rand_addr(), 2'd1, 1'b0);  // learned port
      learned_addr = s1;
      report_test("3 flood and learn");
   endtask

   task automatic test_age();
      apb_write(alut_reg_max_age, 32'h0);
      run_check(learned_addr, rand_addr(), 2'd3, 1'b1);  // out of date
      apb_write(alut_reg_max_age, 32'hFFFF_FFFF);
      run_check(learned_addr, rand_addr(), 2'd0, 1'b0);
      report_test("4 aging");
   endtask

   task automatic test_reuse();
      logic [47:0] a;
      logic [31:0] rd;
      a = rand_addr();
      run_check(rand_addr(), a, 2'd1, 1'b0);
      run_check(rand_addr(), a ^ 48'h0000_0000_0101, 2'd3, 1'b0);  // same index, evicts a
      apb_read(alut_reg_status, rd);
      check_equal("status", 64'(rd), 64'h2);
      apb_read(alut_reg_inv_lo, rd);
      check_equal("inv_lo", 64'(rd), 64'(a[31:0]));
      apb_read(alut_reg_inv_hi, rd);  // also clears reused
      check_equal("inv_hi", 64'(rd), 64'({14'd0, 2'd1, a[47:32]}));
      apb_read(alut_reg_status, rd);
      check_equal("status", 64'(rd), 64'h0);
      report_test("5 reuse");
   endtask

   initial
   begin
      seed         = 1;
      errors       = 0;
      test_errors  = 0;
      tests_failed = 0;
      mac          = '0;
      learned_addr = '0;
      pclk12       = 1'b0;
      n_p_reset12  = 1'b0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      repeat (4) @(posedge pclk12);
      #1 n_p_reset12 = 1'b1;
      test_reset();
      test_mac_hit();
      test_learn();
      test_age();
      test_reuse();
      $display("%0d tests run, %0d failed, %0d check errors", num_tests, tests_failed, errors);
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   // watchdog
   initial
   begin
      #((num_tests * cycles_per_test + 4) * clk_period);
      $display("timeout, tests did not complete within %0d cycles", num_tests * cycles_per_test);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
source/alut_pkg.sv
source/alut_apb_regs.sv
source/alut_addr_checker.sv
source/alut_age_checker.sv
source/alut_mem.sv
source/alut_top.sv
verif/alut_sva.sv
verif/tb_alut.sv

/* Makefile */
# Verilator build and run of the alut testbench

VERILATOR ?= verilator
TOP       ?= tb_alut
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
